// File: common/core_pkg.sv
package core_pkg;

    // integer datapath
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;

    // memory operation carried down from execute
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_ld   = 4'd4,
        op_lbu  = 4'd5,
        op_lhu  = 4'd6,
        op_lwu  = 4'd7,
        op_sb   = 4'd8,
        op_sh   = 4'd9,
        op_sw   = 4'd10,
        op_sd   = 4'd11
    } mem_op_e;

    // per-stage stall vector
    localparam int stall_w   = 5;
    localparam int stall_if  = 0;
    localparam int stall_id  = 1;
    localparam int stall_ex  = 2;
    localparam int stall_mem = 3;
    localparam int stall_wb  = 4;

endpackage

// File: common/mem_pkg.sv
package mem_pkg;

    localparam int mem_word_w = 64;
    // word address, 1024 words
    localparam int mem_addr_w = 10;

    // one memory word seen at byte, half or word granularity
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } mem_word_u;

endpackage

// File: memory/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_depth_log2 = 10
) (
    input  logic                           clk,
    input  logic                           en_i,
    input  logic                           we_i,
    input  logic [7:0]                     be_i,
    input  logic [ram_depth_log2-1:0]      addr_i,
    input  logic [mem_pkg::mem_word_w-1:0] wdata_i,
    output logic [mem_pkg::mem_word_w-1:0] rdata_o
);

    logic [mem_pkg::mem_word_w-1:0] mem [2**ram_depth_log2];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                // byte lanes written independently
                for (int i = 0; i < 8; i++) begin
                    if (be_i[i]) begin
                        mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// File: memory/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int ram_depth_log2 = 10
) (
    input  logic                           clk,
    input  logic                           reset_i,
    // load/store port
    input  logic                           ls_req_i,
    input  logic                           ls_we_i,
    input  logic [7:0]                     ls_be_i,
    input  logic [ram_depth_log2-1:0]      ls_addr_i,
    input  logic [mem_pkg::mem_word_w-1:0] ls_wdata_i,
    output logic                           ls_gnt_o,
    output logic [mem_pkg::mem_word_w-1:0] ls_rdata_o,
    // fetch port
    input  logic                           if_req_i,
    input  logic [ram_depth_log2-1:0]      if_addr_i,
    output logic                           if_gnt_o,
    output logic [mem_pkg::mem_word_w-1:0] if_rdata_o,
    // ram side
    output logic                           ram_en_o,
    output logic                           ram_we_o,
    output logic [7:0]                     ram_be_o,
    output logic [ram_depth_log2-1:0]      ram_addr_o,
    output logic [mem_pkg::mem_word_w-1:0] ram_wdata_o,
    input  logic [mem_pkg::mem_word_w-1:0] ram_rdata_i
);

    logic ls_owner_q;

    // load/store always wins
    assign ls_gnt_o = ls_req_i;
    assign if_gnt_o = if_req_i && !ls_req_i;

    assign ram_en_o    = ls_req_i || if_req_i;
    assign ram_we_o    = ls_req_i && ls_we_i;
    assign ram_be_o    = ls_be_i;
    assign ram_addr_o  = ls_req_i ? ls_addr_i : if_addr_i;
    assign ram_wdata_o = ls_wdata_i;

    // owner of the read that returns this cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ls_owner_q <= 1'b0;
        end else begin
            ls_owner_q <= ls_req_i;
        end
    end

    assign ls_rdata_o = ls_owner_q ? ram_rdata_i : '0;
    assign if_rdata_o = ls_owner_q ? '0 : ram_rdata_i;

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int                        ram_depth_log2 = 10,
    parameter logic [core_pkg::xlen-1:0] reset_pc       = '0
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           stall_i,
    output logic                           if_req_o,
    output logic [ram_depth_log2-1:0]      if_addr_o,
    input  logic                           if_gnt_i,
    input  logic [mem_pkg::mem_word_w-1:0] if_rdata_i,
    output logic [core_pkg::xlen-1:0]      pc_o,
    output logic [31:0]                    instr_o,
    output logic                           if_valid_o
);

    logic [core_pkg::xlen-1:0] pc_q;
    logic [core_pkg::xlen-1:0] fetch_pc_q;
    logic                      fetch_en_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q       <= reset_pc;
            fetch_pc_q <= reset_pc;
            fetch_en_q <= 1'b0;
            if_valid_o <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
            if_valid_o <= if_gnt_i && !stall_i;
            if (if_gnt_i && !stall_i) begin
                fetch_pc_q <= pc_q;
                pc_q       <= pc_q + 4;
            end
        end
    end

    // first request goes out one cycle after reset
    assign if_req_o  = fetch_en_q;
    assign if_addr_o = pc_q[ram_depth_log2+2:3];

    // two instructions per word
    assign pc_o    = fetch_pc_q;
    assign instr_o = fetch_pc_q[2] ? if_rdata_i[63:32] : if_rdata_i[31:0];

endmodule

// File: src/lsu.sv
`timescale 1ns/1ps

module lsu #(
    parameter int ram_depth_log2 = 10
) (
    input  logic                            clk,
    input  logic                            reset_i,
    // from execute
    input  logic [core_pkg::xlen-1:0]       ex_alu_i,
    input  logic [core_pkg::reg_addr_w-1:0] ex_rd_addr_i,
    input  logic                            ex_rd_ena_i,
    input  core_pkg::mem_op_e               ex_mem_op_i,
    input  logic [core_pkg::xlen-1:0]       ex_store_data_i,
    // arbiter side
    output logic                            ls_req_o,
    output logic                            ls_we_o,
    output logic [7:0]                      ls_be_o,
    output logic [ram_depth_log2-1:0]       ls_addr_o,
    output logic [mem_pkg::mem_word_w-1:0]  ls_wdata_o,
    input  logic                            ls_gnt_i,
    input  logic [mem_pkg::mem_word_w-1:0]  ls_rdata_i,
    // results
    output logic                            lsu_wait_o,
    output logic [core_pkg::xlen-1:0]       mem_rd_data_o,
    output logic [core_pkg::reg_addr_w-1:0] mem_rd_addr_o,
    output logic                            mem_rd_ena_o
);

    logic [2:0]                offset;
    logic                      is_store;
    logic                      is_load;
    logic [7:0]                be_base;
    logic                      pend_q;
    logic [2:0]                pend_off_q;
    core_pkg::mem_op_e         pend_op_q;
    mem_pkg::mem_word_u        rdata_u;
    logic [core_pkg::xlen-1:0] load_data;

    assign offset   = ex_alu_i[2:0];
    assign is_store = ex_mem_op_i inside {core_pkg::op_sb, core_pkg::op_sh,
                                          core_pkg::op_sw, core_pkg::op_sd};
    assign is_load  = (ex_mem_op_i != core_pkg::op_none) && !is_store;

    // lane mask by access size
    always_comb begin
        case (ex_mem_op_i)
            core_pkg::op_lb, core_pkg::op_lbu, core_pkg::op_sb: be_base = 8'h01;
            core_pkg::op_lh, core_pkg::op_lhu, core_pkg::op_sh: be_base = 8'h03;
            core_pkg::op_lw, core_pkg::op_lwu, core_pkg::op_sw: be_base = 8'h0f;
            default:                                            be_base = 8'hff;
        endcase
    end

    // held load must not issue twice
    assign ls_req_o   = (ex_mem_op_i != core_pkg::op_none) && !pend_q;
    assign ls_we_o    = is_store;
    assign ls_be_o    = be_base << offset;
    assign ls_addr_o  = ex_alu_i[ram_depth_log2+2:3];
    assign ls_wdata_o = ex_store_data_i << {offset, 3'b000};
    assign lsu_wait_o = is_load && !pend_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= is_load && ls_gnt_i && !pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (is_load && ls_gnt_i) begin
            pend_off_q <= offset;
            pend_op_q  <= ex_mem_op_i;
        end
    end

    // pick the lane, then sign or zero extend
    always_comb begin
        rdata_u = ls_rdata_i;
        case (pend_op_q)
            core_pkg::op_lb:  load_data = {{56{rdata_u.bytes[pend_off_q][7]}},
                                           rdata_u.bytes[pend_off_q]};
            core_pkg::op_lbu: load_data = {56'b0, rdata_u.bytes[pend_off_q]};
            core_pkg::op_lh:  load_data = {{48{rdata_u.halves[pend_off_q[2:1]][15]}},
                                           rdata_u.halves[pend_off_q[2:1]]};
            core_pkg::op_lhu: load_data = {48'b0, rdata_u.halves[pend_off_q[2:1]]};
            core_pkg::op_lw:  load_data = {{32{rdata_u.words[pend_off_q[2]][31]}},
                                           rdata_u.words[pend_off_q[2]]};
            core_pkg::op_lwu: load_data = {32'b0, rdata_u.words[pend_off_q[2]]};
            default:          load_data = ls_rdata_i;
        endcase
    end

    assign mem_rd_data_o = pend_q ? load_data : ex_alu_i;
    assign mem_rd_addr_o = ex_rd_addr_i;
    assign mem_rd_ena_o  = ex_rd_ena_i;

endmodule

// File: src/stall_unit.sv
`timescale 1ns/1ps

module stall_unit (
    input  logic                         lsu_wait_i,
    input  logic                         if_gnt_i,
    input  logic                         if_req_i,
    output logic [core_pkg::stall_w-1:0] stall_o
);

    always_comb begin
        stall_o = '0;
        if (lsu_wait_i) begin
            // memory wait freezes everything, wb gets a bubble
            stall_o[core_pkg::stall_if]  = 1'b1;
            stall_o[core_pkg::stall_id]  = 1'b1;
            stall_o[core_pkg::stall_ex]  = 1'b1;
            stall_o[core_pkg::stall_mem] = 1'b1;
            stall_o[core_pkg::stall_wb]  = 1'b1;
        end else if (if_req_i && !if_gnt_i) begin
            // lost arbitration, hold fetch only
            stall_o[core_pkg::stall_if] = 1'b1;
        end
    end

endmodule

// File: src/mem_wb.sv
`timescale 1ns/1ps

module mem_wb (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [core_pkg::stall_w-1:0]    stall_ctrl_i,
    input  logic [core_pkg::xlen-1:0]       mem_rd_data_i,
    input  logic [core_pkg::reg_addr_w-1:0] mem_rd_addr_i,
    input  logic                            mem_rd_ena_i,
    output logic [core_pkg::xlen-1:0]       wb_rd_data_o,
    output logic [core_pkg::reg_addr_w-1:0] wb_rd_addr_o,
    output logic                            wb_rd_ena_o
);

    logic lower_stalled;

    assign lower_stalled = &stall_ctrl_i[core_pkg::stall_mem:core_pkg::stall_if];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
        end else if (!stall_ctrl_i[core_pkg::stall_wb]) begin
            wb_rd_ena_o  <= mem_rd_ena_i;
            wb_rd_addr_o <= mem_rd_addr_i;
            wb_rd_data_o <= mem_rd_data_i;
        end else if (lower_stalled) begin
            // bubble
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= '0;
        end
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            we_i,
    input  logic [core_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [core_pkg::xlen-1:0]       wdata_i,
    input  logic [core_pkg::reg_addr_w-1:0] raddr1_i,
    output logic [core_pkg::xlen-1:0]       rdata1_o,
    input  logic [core_pkg::reg_addr_w-1:0] raddr2_i,
    output logic [core_pkg::xlen-1:0]       rdata2_o
);

    logic [core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 hardwired, no write forwarding
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: src/backend_top.sv
`timescale 1ns/1ps

module backend_top #(
    parameter int                        ram_depth_log2 = mem_pkg::mem_addr_w,
    parameter logic [core_pkg::xlen-1:0] reset_pc       = '0
) (
    input  logic                            clk,
    input  logic                            reset_i,
    // execute stage stand-in, ex_pc_i kept for debug
    input  logic [core_pkg::xlen-1:0]       ex_pc_i,
    input  logic [core_pkg::xlen-1:0]       ex_alu_i,
    input  logic [core_pkg::reg_addr_w-1:0] ex_rd_addr_i,
    input  logic                            ex_rd_ena_i,
    input  core_pkg::mem_op_e               ex_mem_op_i,
    input  logic [core_pkg::xlen-1:0]       ex_store_data_i,
    output logic [core_pkg::stall_w-1:0]    stall_o,
    // fetch
    output logic [core_pkg::xlen-1:0]       pc_o,
    output logic [31:0]                     instr_o,
    output logic                            if_valid_o,
    // register read ports
    input  logic [core_pkg::reg_addr_w-1:0] raddr1_i,
    output logic [core_pkg::xlen-1:0]       rdata1_o,
    input  logic [core_pkg::reg_addr_w-1:0] raddr2_i,
    output logic [core_pkg::xlen-1:0]       rdata2_o
);

    logic                            ls_req, ls_we, ls_gnt;
    logic [7:0]                      ls_be;
    logic [ram_depth_log2-1:0]       ls_addr;
    logic [mem_pkg::mem_word_w-1:0]  ls_wdata, ls_rdata;
    logic                            if_req, if_gnt;
    logic [ram_depth_log2-1:0]       if_addr;
    logic [mem_pkg::mem_word_w-1:0]  if_rdata;
    logic                            ram_en, ram_we;
    logic [7:0]                      ram_be;
    logic [ram_depth_log2-1:0]       ram_addr;
    logic [mem_pkg::mem_word_w-1:0]  ram_wdata, ram_rdata;
    logic                            lsu_wait;
    logic [core_pkg::xlen-1:0]       mem_rd_data, wb_rd_data;
    logic [core_pkg::reg_addr_w-1:0] mem_rd_addr, wb_rd_addr;
    logic                            mem_rd_ena, wb_rd_ena;

    data_ram #(.ram_depth_log2(ram_depth_log2)) data_ram_inst (
        .clk(clk), .en_i(ram_en), .we_i(ram_we), .be_i(ram_be),
        .addr_i(ram_addr), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

    mem_arbiter #(.ram_depth_log2(ram_depth_log2)) mem_arbiter_inst (
        .clk(clk), .reset_i(reset_i),
        .ls_req_i(ls_req), .ls_we_i(ls_we), .ls_be_i(ls_be), .ls_addr_i(ls_addr),
        .ls_wdata_i(ls_wdata), .ls_gnt_o(ls_gnt), .ls_rdata_o(ls_rdata),
        .if_req_i(if_req), .if_addr_i(if_addr), .if_gnt_o(if_gnt), .if_rdata_o(if_rdata),
        .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_be_o(ram_be), .ram_addr_o(ram_addr),
        .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata)
    );

    fetch_unit #(.ram_depth_log2(ram_depth_log2), .reset_pc(reset_pc)) fetch_unit_inst (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_o[core_pkg::stall_if]),
        .if_req_o(if_req), .if_addr_o(if_addr), .if_gnt_i(if_gnt), .if_rdata_i(if_rdata),
        .pc_o(pc_o), .instr_o(instr_o), .if_valid_o(if_valid_o)
    );

    lsu #(.ram_depth_log2(ram_depth_log2)) lsu_inst (
        .clk(clk), .reset_i(reset_i),
        .ex_alu_i(ex_alu_i), .ex_rd_addr_i(ex_rd_addr_i), .ex_rd_ena_i(ex_rd_ena_i),
        .ex_mem_op_i(ex_mem_op_i), .ex_store_data_i(ex_store_data_i),
        .ls_req_o(ls_req), .ls_we_o(ls_we), .ls_be_o(ls_be), .ls_addr_o(ls_addr),
        .ls_wdata_o(ls_wdata), .ls_gnt_i(ls_gnt), .ls_rdata_i(ls_rdata),
        .lsu_wait_o(lsu_wait), .mem_rd_data_o(mem_rd_data),
        .mem_rd_addr_o(mem_rd_addr), .mem_rd_ena_o(mem_rd_ena)
    );

    stall_unit stall_unit_inst (
        .lsu_wait_i(lsu_wait), .if_gnt_i(if_gnt), .if_req_i(if_req), .stall_o(stall_o)
    );

    mem_wb mem_wb_inst (
        .clk(clk), .reset_i(reset_i), .stall_ctrl_i(stall_o),
        .mem_rd_data_i(mem_rd_data), .mem_rd_addr_i(mem_rd_addr), .mem_rd_ena_i(mem_rd_ena),
        .wb_rd_data_o(wb_rd_data), .wb_rd_addr_o(wb_rd_addr), .wb_rd_ena_o(wb_rd_ena)
    );

    regfile regfile_inst (
        .clk(clk), .reset_i(reset_i),
        .we_i(wb_rd_ena), .waddr_i(wb_rd_addr), .wdata_i(wb_rd_data),
        .raddr1_i(raddr1_i), .rdata1_o(rdata1_o), .raddr2_i(raddr2_i), .rdata2_o(rdata2_o)
    );

endmodule

// File: verification/backend_props.sv
`timescale 1ns/1ps

module backend_props (
    input logic                            clk,
    input logic                            reset_i,
    input logic [core_pkg::stall_w-1:0]    stall_i,
    input logic                            wb_rd_ena_i,
    input logic [core_pkg::reg_addr_w-1:0] wb_rd_addr_i,
    input logic [core_pkg::xlen-1:0]       wb_rd_data_i,
    input logic                            ls_gnt_i,
    input logic                            if_gnt_i
);

    // full stall loads a bubble into mem_wb
    bubble_zeroes_wb: assert property (@(posedge clk) disable iff (reset_i)
        &stall_i |=> !wb_rd_ena_i && wb_rd_addr_i == '0 && wb_rd_data_i == '0)
        else $error("mem_wb did not clear on a bubble");

    single_grant: assert property (@(posedge clk) disable iff (reset_i)
        !(ls_gnt_i && if_gnt_i))
        else $error("arbiter granted both ports");

    wb_idle_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> !wb_rd_ena_i)
        else $error("wb write enable high right after reset");

endmodule

bind backend_top backend_props backend_props_inst (
    .clk(clk), .reset_i(reset_i), .stall_i(stall_o),
    .wb_rd_ena_i(wb_rd_ena), .wb_rd_addr_i(wb_rd_addr), .wb_rd_data_i(wb_rd_data),
    .ls_gnt_i(ls_gnt), .if_gnt_i(if_gnt)
);

// File: verification/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;

    localparam int clk_period      = 10;
    localparam int reset_cycles    = 5;
    localparam int num_tests       = 5;
    localparam int cycles_per_test = 200;
    localparam int max_hold        = 8;

    logic                            clk;
    logic                            reset_i;
    logic [core_pkg::xlen-1:0]       ex_pc_i;
    logic [core_pkg::xlen-1:0]       ex_alu_i;
    logic [core_pkg::reg_addr_w-1:0] ex_rd_addr_i;
    logic                            ex_rd_ena_i;
    core_pkg::mem_op_e               ex_mem_op_i;
    logic [core_pkg::xlen-1:0]       ex_store_data_i;
    logic [core_pkg::stall_w-1:0]    stall_o;
    logic [core_pkg::xlen-1:0]       pc_o;
    logic [31:0]                     instr_o;
    logic                            if_valid_o;
    logic [core_pkg::reg_addr_w-1:0] raddr1_i;
    logic [core_pkg::xlen-1:0]       rdata1_o;
    logic [core_pkg::reg_addr_w-1:0] raddr2_i;
    logic [core_pkg::xlen-1:0]       rdata2_o;

    // reference state
    logic [63:0] model_mem [1024];
    logic [63:0] model_regs [32];
    logic [15:0] lfsr_q;

    backend_top backend_top_inst (
        .clk(clk), .reset_i(reset_i), .ex_pc_i(ex_pc_i), .ex_alu_i(ex_alu_i),
        .ex_rd_addr_i(ex_rd_addr_i), .ex_rd_ena_i(ex_rd_ena_i), .ex_mem_op_i(ex_mem_op_i),
        .ex_store_data_i(ex_store_data_i), .stall_o(stall_o), .pc_o(pc_o),
        .instr_o(instr_o), .if_valid_o(if_valid_o), .raddr1_i(raddr1_i),
        .rdata1_o(rdata1_o), .raddr2_i(raddr2_i), .rdata2_o(rdata2_o)
    );

    always #(clk_period / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_shift(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] random_bits(input int nbits);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_shift(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int access_bytes(input core_pkg::mem_op_e op);
        case (op)
            core_pkg::op_lb, core_pkg::op_lbu, core_pkg::op_sb: return 1;
            core_pkg::op_lh, core_pkg::op_lhu, core_pkg::op_sh: return 2;
            core_pkg::op_lw, core_pkg::op_lwu, core_pkg::op_sw: return 4;
            default: return 8;
        endcase
    endfunction

    // little endian, byte lanes from the low address bits
    function automatic void model_store(input core_pkg::mem_op_e op, input logic [63:0] addr,
                                        input logic [63:0] data);
        for (int i = 0; i < access_bytes(op); i++) begin
            model_mem[addr[12:3]][(addr[2:0] + i) * 8 +: 8] = data[i*8 +: 8];
        end
    endfunction

    function automatic logic [63:0] expected_load(input core_pkg::mem_op_e op,
                                                  input logic [63:0] addr);
        logic [63:0] raw;
        raw = model_mem[addr[12:3]] >> (addr[2:0] * 8);
        case (op)
            core_pkg::op_lb:  return {{56{raw[7]}}, raw[7:0]};
            core_pkg::op_lh:  return {{48{raw[15]}}, raw[15:0]};
            core_pkg::op_lw:  return {{32{raw[31]}}, raw[31:0]};
            core_pkg::op_lbu: return {56'b0, raw[7:0]};
            core_pkg::op_lhu: return {48'b0, raw[15:0]};
            core_pkg::op_lwu: return {32'b0, raw[31:0]};
            default:          return raw;
        endcase
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%0t ns: %s", $time, reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // every helper starts and ends 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_inputs(input core_pkg::mem_op_e op, input logic [63:0] alu,
                                input logic [4:0] rd, input logic ena,
                                input logic [63:0] sdata);
        ex_mem_op_i     = op;
        ex_alu_i        = alu;
        ex_rd_addr_i    = rd;
        ex_rd_ena_i     = ena;
        ex_store_data_i = sdata;
        ex_pc_i         = ex_pc_i + 4;
    endtask

    task automatic set_idle();
        ex_mem_op_i     = core_pkg::op_none;
        ex_alu_i        = '0;
        ex_rd_addr_i    = '0;
        ex_rd_ena_i     = 1'b0;
        ex_store_data_i = '0;
    endtask

    // hold inputs while execute is stalled, return the number of held cycles
    task automatic issue_op(input core_pkg::mem_op_e op, input logic [63:0] alu,
                            input logic [4:0] rd, input logic ena,
                            input logic [63:0] sdata, output int held);
        held = 0;
        drive_inputs(op, alu, rd, ena, sdata);
        @(negedge clk);
        while (stall_o[core_pkg::stall_ex]) begin
            check_equal("stall vector during memory wait", stall_o, 5'b11111);
            held++;
            if (held > max_hold) begin
                abort_run("memory stall did not clear, the pipeline is stuck");
            end else begin
                next_cycle();
                @(negedge clk);
            end
        end
        next_cycle();
        set_idle();
    endtask

    task automatic check_reg(input int r, input logic [63:0] expected);
        raddr1_i = r;
        raddr2_i = r;
        @(negedge clk);
        check_equal($sformatf("x%0d on read port 1", r), rdata1_o, expected);
        check_equal($sformatf("x%0d on read port 2", r), rdata2_o, expected);
    endtask

    task automatic alu_write(input int r, input logic [63:0] value);
        int held;
        issue_op(core_pkg::op_none, value, r, 1'b1, '0, held);
        check_equal("stall cycles of an alu result", held, 0);
        check_reg(r, model_regs[r]);
        next_cycle();
        if (r != 0) begin
            model_regs[r] = value;
        end
        check_reg(r, model_regs[r]);
        next_cycle();
    endtask

    task automatic store_op(input core_pkg::mem_op_e op, input logic [63:0] addr,
                            input logic [63:0] data);
        int held;
        model_store(op, addr, data);
        issue_op(op, addr, '0, 1'b0, data, held);
        check_equal("stall cycles of a store", held, 0);
    endtask

    task automatic load_op(input core_pkg::mem_op_e op, input logic [63:0] addr,
                           input int r);
        int          held;
        logic [63:0] expected;
        expected = expected_load(op, addr);
        issue_op(op, addr, r, 1'b1, '0, held);
        check_equal("stall cycles of a load", held, 1);
        check_reg(r, model_regs[r]);
        next_cycle();
        model_regs[r] = expected;
        check_reg(r, expected);
        next_cycle();
    endtask

    task automatic check_fetch(input logic [63:0] pc_exp);
        logic [63:0] word;
        word = model_mem[pc_exp[12:3]];
        @(negedge clk);
        check_equal("fetch valid", if_valid_o, 1'b1);
        check_equal("fetch pc", pc_o, pc_exp);
        check_equal("fetched instruction", instr_o, pc_exp[2] ? word[63:32] : word[31:0]);
    endtask

    task automatic alu_writeback();
        for (int r = 1; r < 32; r++) begin
            alu_write(r, random_bits(64));
        end
        alu_write(0, random_bits(64));
    endtask

    task automatic store_load_round_trip();
        for (int i = 0; i < 8; i++) begin
            store_op(core_pkg::op_sd, 64'h1000 + i * 8, random_bits(64));
        end
        for (int i = 0; i < 8; i++) begin
            load_op(core_pkg::op_ld, 64'h1000 + i * 8, 8 + i);
        end
    endtask

    // byte, half and word lanes of one doubleword, both signs covered
    task automatic subword_access();
        logic [63:0] base;
        base = 64'h1800;
        store_op(core_pkg::op_sd, base, random_bits(64));
        store_op(core_pkg::op_sb, base + 1, random_bits(8) | 64'h80);
        store_op(core_pkg::op_sh, base + 2, random_bits(16) & 64'h7fff);
        store_op(core_pkg::op_sw, base + 4, random_bits(32) | 64'h8000_0000);
        load_op(core_pkg::op_lb, base + 1, 16);
        load_op(core_pkg::op_lbu, base + 1, 17);
        load_op(core_pkg::op_lh, base + 2, 18);
        load_op(core_pkg::op_lhu, base + 2, 19);
        load_op(core_pkg::op_lw, base + 4, 20);
        load_op(core_pkg::op_lwu, base + 4, 21);
        load_op(core_pkg::op_ld, base, 22);
        load_op(core_pkg::op_lb, base, 23);
    endtask

    task automatic bubble_insertion();
        logic [63:0] addr;
        logic [63:0] expected;
        addr = 64'h1008;
        // odd value so it never matches the even load address
        alu_write(24, random_bits(64) | 64'h1);
        expected = expected_load(core_pkg::op_ld, addr);
        drive_inputs(core_pkg::op_ld, addr, 5'd24, 1'b1, '0);
        @(negedge clk);
        check_equal("stall vector in load wait", stall_o, 5'b11111);
        next_cycle();
        check_reg(24, model_regs[24]);
        check_equal("stall vector after load wait", stall_o, 0);
        next_cycle();
        set_idle();
        // wb would have written the address here without the bubble
        check_reg(24, model_regs[24]);
        next_cycle();
        model_regs[24] = expected;
        check_reg(24, expected);
        next_cycle();
    endtask

    task automatic fetch_sharing();
        logic [63:0] pc_start;
        logic [63:0] pc_exp;
        logic [63:0] base;
        pc_start = pc_o;
        base = {pc_start[63:3], 3'b000};
        // fetch is blocked for the whole fill
        for (int i = 0; i < 32; i++) begin
            store_op(core_pkg::op_sd, base + i * 8, random_bits(64));
        end
        @(negedge clk);
        check_equal("fetch valid after lost arbitration", if_valid_o, 1'b0);
        check_equal("pc held during stores", pc_o, pc_start);
        pc_exp = pc_start;
        for (int i = 0; i < 40; i++) begin
            next_cycle();
            pc_exp = pc_exp + 4;
            check_fetch(pc_exp);
        end
        next_cycle();
        pc_exp = pc_exp + 4;
        // one instruction per load, fetched in the load's second cycle
        for (int i = 0; i < 4; i++) begin
            drive_inputs(core_pkg::op_ld, base + i * 8, '0, 1'b0, '0);
            check_fetch(pc_exp);
            check_equal("stall vector in load wait", stall_o, 5'b11111);
            next_cycle();
            @(negedge clk);
            check_equal("fetch valid during load wait", if_valid_o, 1'b0);
            check_equal("pc during load wait", pc_o, pc_exp);
            next_cycle();
            pc_exp = pc_exp + 4;
        end
        set_idle();
        check_fetch(pc_exp);
        next_cycle();
    endtask

    initial begin
        clk     = 1'b0;
        reset_i = 1'b1;
        ex_pc_i = '0;
        set_idle();
        raddr1_i = '0;
        raddr2_i = '0;
        lfsr_q   = 16'd34;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset_i = 1'b0;
        alu_writeback();
        store_load_round_trip();
        subword_access();
        bubble_insertion();
        fetch_sharing();
        $display("Test OK");
        $finish;
    end

    // watchdog
    initial begin
        #((reset_cycles + num_tests * cycles_per_test) * clk_period);
        $display("Timeout: the tests did not finish within %0d cycles",
                 reset_cycles + num_tests * cycles_per_test);
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

// File: src.f
common/core_pkg.sv
common/mem_pkg.sv
memory/data_ram.sv
memory/mem_arbiter.sv
src/fetch_unit.sv
src/lsu.sv
src/stall_unit.sv
src/mem_wb.sv
src/regfile.sv
src/backend_top.sv
verification/backend_props.sv
verification/backend_tb.sv
